// ==== design/wt_cache_pkg.sv ====
package wt_cache_pkg;

   // axi write response codes
   localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
   localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

   // fixed write attributes
   localparam logic [3:0] AXI_CACHE_ATTR  = 4'b0011;   // bufferable, modifiable
   localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
   localparam logic [7:0] AXI_LEN_SINGLE  = 8'd0;      // one beat per store

   // default geometry
   localparam int unsigned DEF_ADDR_W    = 32;         // byte address
   localparam int unsigned DEF_DATA_W    = 32;         // processor word
   localparam int unsigned DEF_BE_DATA_W = 64;         // memory beat
   localparam int unsigned DEF_BUF_DEPTH = 4;          // pending stores
   localparam int unsigned DEF_AXI_ID_W  = 1;
   localparam int unsigned DEF_AXI_ID    = 0;          // single fixed id

   // log2 of the byte count of a bus of the given bit width
   function automatic int unsigned bytes_w(input int unsigned width);
      int unsigned nbytes;
      int unsigned lg;
      nbytes = width / 8;
      lg     = 0;
      while ((1 << lg) < nbytes) begin
         lg = lg + 1;
      end
      return lg;
   endfunction

endpackage

// ==== design/wt_write_buffer.sv ====
`timescale 1ns/1ps

module wt_write_buffer #(
   parameter int unsigned ADDR_W    = wt_cache_pkg::DEF_ADDR_W,
   parameter int unsigned DATA_W    = wt_cache_pkg::DEF_DATA_W,
   parameter int unsigned BUF_DEPTH = wt_cache_pkg::DEF_BUF_DEPTH
) (
   input  logic                                           clk_i,
   input  logic                                           reset,
   input  logic                                           push_i,
   input  logic [ADDR_W-wt_cache_pkg::bytes_w(DATA_W)-1:0] push_addr_i,
   input  logic [DATA_W-1:0]                              push_wdata_i,
   input  logic [DATA_W/8-1:0]                            push_wstrb_i,
   input  logic                                           pop_i,
   output logic                                           full_o,
   output logic                                           empty_o,
   output logic [ADDR_W-wt_cache_pkg::bytes_w(DATA_W)-1:0] head_addr_o,
   output logic [DATA_W-1:0]                              head_wdata_o,
   output logic [DATA_W/8-1:0]                            head_wstrb_o
);

   import wt_cache_pkg::*;

   localparam int unsigned WORD_ADDR_W = ADDR_W - bytes_w(DATA_W);
   localparam int unsigned PTR_W       = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int unsigned CNT_W       = $clog2(BUF_DEPTH + 1);

   // storage, payload only
   logic [WORD_ADDR_W-1:0] addr_mem  [BUF_DEPTH];
   logic [DATA_W-1:0]      wdata_mem [BUF_DEPTH];
   logic [DATA_W/8-1:0]    wstrb_mem [BUF_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push_ok;
   logic             pop_ok;

   assign full_o  = (count_q == CNT_W'(BUF_DEPTH));
   assign empty_o = (count_q == '0);
   assign push_ok = push_i & ~full_o;   // dropped when full
   assign pop_ok  = pop_i & ~empty_o;

   // oldest entry is always visible
   assign head_addr_o  = addr_mem[rd_ptr_q];
   assign head_wdata_o = wdata_mem[rd_ptr_q];
   assign head_wstrb_o = wstrb_mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push_ok) begin
         addr_mem[wr_ptr_q]  <= push_addr_i;
         wdata_mem[wr_ptr_q] <= push_wdata_i;
         wstrb_mem[wr_ptr_q] <= push_wstrb_i;
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         // both at once leaves the count alone
         if (push_ok & ~pop_ok) begin
            count_q <= count_q + 1'b1;
         end else if (pop_ok & ~push_ok) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

// ==== design/wt_write_decode.sv ====
`timescale 1ns/1ps

module wt_write_decode #(
   parameter int unsigned ADDR_W    = wt_cache_pkg::DEF_ADDR_W,
   parameter int unsigned DATA_W    = wt_cache_pkg::DEF_DATA_W,
   parameter int unsigned BE_DATA_W = wt_cache_pkg::DEF_BE_DATA_W
) (
   input  logic [ADDR_W-wt_cache_pkg::bytes_w(DATA_W)-1:0] word_addr_i,
   input  logic [DATA_W-1:0]                              wdata_i,
   input  logic [DATA_W/8-1:0]                            wstrb_i,
   output logic [ADDR_W-1:0]                              beat_addr_o,
   output logic [BE_DATA_W-1:0]                           beat_wdata_o,
   output logic [BE_DATA_W/8-1:0]                         beat_wstrb_o
);

   import wt_cache_pkg::*;

   localparam int unsigned NB      = DATA_W / 8;
   localparam int unsigned BE_NB   = BE_DATA_W / 8;
   localparam int unsigned NB_W    = bytes_w(DATA_W);      // byte offset in a word
   localparam int unsigned BE_NB_W = bytes_w(BE_DATA_W);   // byte offset in a beat

   logic [ADDR_W-1:0] byte_addr;

   assign byte_addr = {word_addr_i, {NB_W{1'b0}}};

   generate
      if (BE_DATA_W == DATA_W) begin : g_same_width
         // one word per beat, nothing to steer
         assign beat_addr_o  = byte_addr;
         assign beat_wdata_o = wdata_i;
         assign beat_wstrb_o = wstrb_i;
      end else begin : g_wide_beat
         localparam int unsigned OFF_W = BE_NB_W - NB_W;   // word offset in a beat

         logic [OFF_W-1:0] word_off;

         assign word_off = word_addr_i[OFF_W-1:0];

         // beat aligned byte address
         assign beat_addr_o = {byte_addr[ADDR_W-1:BE_NB_W], {BE_NB_W{1'b0}}};

         // strobe moved to the selected lane
         assign beat_wstrb_o = {{(BE_NB - NB){1'b0}}, wstrb_i} << (word_off * NB);

         // same word on every lane, the strobe picks
         assign beat_wdata_o = {(BE_DATA_W / DATA_W){wdata_i}};
      end
   endgenerate

endmodule

// ==== design/wt_write_channel_axi.sv ====
`timescale 1ns/1ps

module wt_write_channel_axi #(
   parameter int unsigned ADDR_W    = wt_cache_pkg::DEF_ADDR_W,
   parameter int unsigned BE_DATA_W = wt_cache_pkg::DEF_BE_DATA_W,
   parameter int unsigned AXI_ID_W  = wt_cache_pkg::DEF_AXI_ID_W
) (
   input  logic                   clk_i,
   input  logic                   reset,
   // command from the decode stage
   input  logic                   cmd_valid_i,
   input  logic [ADDR_W-1:0]      beat_addr_i,
   input  logic [BE_DATA_W-1:0]   beat_wdata_i,
   input  logic [BE_DATA_W/8-1:0] beat_wstrb_i,
   // write address
   output logic                   axi_awvalid_o,
   input  logic                   axi_awready_i,
   output logic [ADDR_W-1:0]      axi_awaddr_o,
   output logic [AXI_ID_W-1:0]    axi_awid_o,
   output logic [7:0]             axi_awlen_o,
   output logic [2:0]             axi_awsize_o,
   output logic [1:0]             axi_awburst_o,
   output logic [3:0]             axi_awcache_o,
   // write data
   output logic                   axi_wvalid_o,
   input  logic                   axi_wready_i,
   output logic [BE_DATA_W-1:0]   axi_wdata_o,
   output logic [BE_DATA_W/8-1:0] axi_wstrb_o,
   output logic                   axi_wlast_o,
   // write response
   input  logic                   axi_bvalid_i,
   output logic                   axi_bready_o,
   input  logic [1:0]             axi_bresp_i,
   // status
   output logic                   done_o,
   output logic                   retry_o,
   output logic                   idle_o
);

   import wt_cache_pkg::*;

   localparam int unsigned BE_NB_W = bytes_w(BE_DATA_W);

   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_ADDR   = 2'd1,
      ST_WRITE  = 2'd2,
      ST_VERIFY = 2'd3
   } state_t;

   state_t state_q;
   state_t state_d;
   logic   resp_ok;

   // fixed transaction attributes
   assign axi_awid_o    = AXI_ID_W'(DEF_AXI_ID);
   assign axi_awlen_o   = AXI_LEN_SINGLE;
   assign axi_awsize_o  = 3'(BE_NB_W);       // full beat
   assign axi_awburst_o = AXI_BURST_FIXED;
   assign axi_awcache_o = AXI_CACHE_ATTR;
   assign axi_wlast_o   = axi_wvalid_o;      // single beat

   // head is held until done, so payload is stable
   assign axi_awaddr_o = beat_addr_i;
   assign axi_wdata_o  = beat_wdata_i;
   assign axi_wstrb_o  = beat_wstrb_i;

   assign resp_ok = (axi_bresp_i == AXI_RESP_OKAY);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (cmd_valid_i) state_d = ST_ADDR;
         end
         ST_ADDR: begin
            if (!cmd_valid_i) begin
               state_d = ST_IDLE;            // buffer ran dry after a pop
            end else if (axi_awready_i) begin
               state_d = ST_WRITE;
            end
         end
         ST_WRITE: begin
            if (axi_wready_i) state_d = ST_VERIFY;
         end
         default: begin
            // okay moves to the next head, error replays this one
            if (axi_bvalid_i) state_d = ST_ADDR;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign axi_awvalid_o = (state_q == ST_ADDR) & cmd_valid_i;
   assign axi_wvalid_o  = (state_q == ST_WRITE);
   assign axi_bready_o  = (state_q == ST_VERIFY);

   assign done_o  = axi_bready_o & axi_bvalid_i & resp_ok;
   assign retry_o = axi_bready_o & axi_bvalid_i & ~resp_ok;

   // an address phase with no command is not holding anything
   assign idle_o = (state_q == ST_IDLE) | ((state_q == ST_ADDR) & ~cmd_valid_i);

endmodule

// ==== design/wt_write_result.sv ====
`timescale 1ns/1ps

module wt_write_result (
   input  logic        clk_i,
   input  logic        reset,
   input  logic        done_i,
   input  logic        retry_i,
   input  logic        buf_empty_i,
   input  logic        chan_idle_i,
   output logic [15:0] write_count_o,
   output logic [15:0] retry_count_o,
   output logic        drained_o
);

   localparam logic [15:0] CNT_MAX = 16'hffff;

   logic [15:0] write_count_q;
   logic [15:0] retry_count_q;
   logic        drained_q;

   // acknowledged stores, saturating
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         write_count_q <= '0;
      end else if (done_i && (write_count_q != CNT_MAX)) begin
         write_count_q <= write_count_q + 16'd1;
      end
   end

   // error responses that forced a resend
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         retry_count_q <= '0;
      end else if (retry_i && (retry_count_q != CNT_MAX)) begin
         retry_count_q <= retry_count_q + 16'd1;
      end
   end

   // nothing queued and nothing on the bus
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         drained_q <= 1'b1;                  // empty out of reset
      end else begin
         drained_q <= buf_empty_i & chan_idle_i;
      end
   end

   assign write_count_o = write_count_q;
   assign retry_count_o = retry_count_q;
   assign drained_o     = drained_q;         // fence may proceed

endmodule

// ==== design/wt_write_path_top.sv ====
`timescale 1ns/1ps

module wt_write_path_top #(
   parameter int unsigned ADDR_W    = wt_cache_pkg::DEF_ADDR_W,
   parameter int unsigned DATA_W    = wt_cache_pkg::DEF_DATA_W,
   parameter int unsigned BE_DATA_W = wt_cache_pkg::DEF_BE_DATA_W,
   parameter int unsigned BUF_DEPTH = wt_cache_pkg::DEF_BUF_DEPTH,
   parameter int unsigned AXI_ID_W  = wt_cache_pkg::DEF_AXI_ID_W
) (
   input  logic                                           clk_i,
   input  logic                                           reset,
   // processor store port
   input  logic                                           req_valid_i,
   output logic                                           req_ready_o,
   input  logic [ADDR_W-wt_cache_pkg::bytes_w(DATA_W)-1:0] req_addr_i,
   input  logic [DATA_W-1:0]                              req_wdata_i,
   input  logic [DATA_W/8-1:0]                            req_wstrb_i,
   // axi write address
   output logic                                           axi_awvalid_o,
   input  logic                                           axi_awready_i,
   output logic [ADDR_W-1:0]                              axi_awaddr_o,
   output logic [AXI_ID_W-1:0]                            axi_awid_o,
   output logic [7:0]                                     axi_awlen_o,
   output logic [2:0]                                     axi_awsize_o,
   output logic [1:0]                                     axi_awburst_o,
   output logic [3:0]                                     axi_awcache_o,
   // axi write data
   output logic                                           axi_wvalid_o,
   input  logic                                           axi_wready_i,
   output logic [BE_DATA_W-1:0]                           axi_wdata_o,
   output logic [BE_DATA_W/8-1:0]                         axi_wstrb_o,
   output logic                                           axi_wlast_o,
   // axi write response
   input  logic                                           axi_bvalid_i,
   output logic                                           axi_bready_o,
   input  logic [1:0]                                     axi_bresp_i,
   // status
   output logic [15:0]                                    write_count_o,
   output logic [15:0]                                    retry_count_o,
   output logic                                           drained_o
);

   import wt_cache_pkg::*;

   localparam int unsigned WORD_ADDR_W = ADDR_W - bytes_w(DATA_W);

   logic                   buf_full;
   logic                   buf_empty;
   logic [WORD_ADDR_W-1:0] head_addr;
   logic [DATA_W-1:0]      head_wdata;
   logic [DATA_W/8-1:0]    head_wstrb;
   logic [ADDR_W-1:0]      beat_addr;
   logic [BE_DATA_W-1:0]   beat_wdata;
   logic [BE_DATA_W/8-1:0] beat_wstrb;
   logic                   chan_done;
   logic                   chan_retry;
   logic                   chan_idle;

   assign req_ready_o = ~buf_full;

   wt_write_buffer #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .BUF_DEPTH (BUF_DEPTH)
   ) u_buffer (
      .clk_i        (clk_i),
      .reset        (reset),
      .push_i       (req_valid_i),           // ignored while full
      .push_addr_i  (req_addr_i),
      .push_wdata_i (req_wdata_i),
      .push_wstrb_i (req_wstrb_i),
      .pop_i        (chan_done),
      .full_o       (buf_full),
      .empty_o      (buf_empty),
      .head_addr_o  (head_addr),
      .head_wdata_o (head_wdata),
      .head_wstrb_o (head_wstrb)
   );

   wt_write_decode #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .BE_DATA_W (BE_DATA_W)
   ) u_decode (
      .word_addr_i  (head_addr),
      .wdata_i      (head_wdata),
      .wstrb_i      (head_wstrb),
      .beat_addr_o  (beat_addr),
      .beat_wdata_o (beat_wdata),
      .beat_wstrb_o (beat_wstrb)
   );

   wt_write_channel_axi #(
      .ADDR_W    (ADDR_W),
      .BE_DATA_W (BE_DATA_W),
      .AXI_ID_W  (AXI_ID_W)
   ) u_channel (
      .clk_i         (clk_i),
      .reset         (reset),
      .cmd_valid_i   (~buf_empty),
      .beat_addr_i   (beat_addr),
      .beat_wdata_i  (beat_wdata),
      .beat_wstrb_i  (beat_wstrb),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_awready_i (axi_awready_i),
      .axi_awaddr_o  (axi_awaddr_o),
      .axi_awid_o    (axi_awid_o),
      .axi_awlen_o   (axi_awlen_o),
      .axi_awsize_o  (axi_awsize_o),
      .axi_awburst_o (axi_awburst_o),
      .axi_awcache_o (axi_awcache_o),
      .axi_wvalid_o  (axi_wvalid_o),
      .axi_wready_i  (axi_wready_i),
      .axi_wdata_o   (axi_wdata_o),
      .axi_wstrb_o   (axi_wstrb_o),
      .axi_wlast_o   (axi_wlast_o),
      .axi_bvalid_i  (axi_bvalid_i),
      .axi_bready_o  (axi_bready_o),
      .axi_bresp_i   (axi_bresp_i),
      .done_o        (chan_done),
      .retry_o       (chan_retry),
      .idle_o        (chan_idle)
   );

   wt_write_result u_result (
      .clk_i         (clk_i),
      .reset         (reset),
      .done_i        (chan_done),
      .retry_i       (chan_retry),
      .buf_empty_i   (buf_empty),
      .chan_idle_i   (chan_idle),
      .write_count_o (write_count_o),
      .retry_count_o (retry_count_o),
      .drained_o     (drained_o)
   );

endmodule

// ==== test/tb_axi_slave_model.sv ====
`timescale 1ns/1ps

module tb_axi_slave_model #(
   parameter int unsigned ADDR_W    = 32,
   parameter int unsigned BE_DATA_W = 64,
   parameter int unsigned MEM_BEATS = 64
) (
   input  logic                   clk_i,
   input  logic                   reset,
   input  logic                   aw_stall_i,     // per cycle stall requests
   input  logic                   w_stall_i,
   input  logic                   b_stall_i,
   input  logic                   inject_err_i,   // taken with the address
   input  logic                   awvalid_i,
   output logic                   awready_o,
   input  logic [ADDR_W-1:0]      awaddr_i,
   input  logic                   wvalid_i,
   output logic                   wready_o,
   input  logic [BE_DATA_W-1:0]   wdata_i,
   input  logic [BE_DATA_W/8-1:0] wstrb_i,
   output logic                   bvalid_o,
   input  logic                   bready_i,
   output logic [1:0]             bresp_o
);

   import wt_cache_pkg::*;

   localparam int unsigned OFF_W  = bytes_w(BE_DATA_W);
   localparam int unsigned IDX_W  = $clog2(MEM_BEATS);
   localparam int unsigned CHUNKS = BE_DATA_W / 32;

   typedef enum logic [1:0] {S_AW, S_W, S_B} slv_state_t;

   logic [BE_DATA_W-1:0] mem [MEM_BEATS];
   slv_state_t           state_q;
   logic [IDX_W-1:0]     idx_q;
   logic                 err_q;

   // every 32-bit word gets its own word address scrambled
   initial begin : mem_fill
      int unsigned i;
      int unsigned c;
      for (i = 0; i < MEM_BEATS; i++) begin
         for (c = 0; c < CHUNKS; c++) begin
            mem[i][c*32 +: 32] = (i * CHUNKS + c) * 32'h9e37_79b9;
         end
      end
   end

   assign awready_o = (state_q == S_AW) & ~aw_stall_i;
   assign wready_o  = (state_q == S_W) & ~w_stall_i;
   assign bresp_o   = err_q ? AXI_RESP_SLVERR : AXI_RESP_OKAY;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state_q  <= S_AW;
         idx_q    <= '0;
         err_q    <= 1'b0;
         bvalid_o <= 1'b0;
      end else begin
         case (state_q)
            S_AW: begin
               if (awvalid_i && awready_o) begin
                  idx_q   <= awaddr_i[OFF_W +: IDX_W];
                  err_q   <= inject_err_i;
                  state_q <= S_W;
               end
            end
            S_W: begin
               if (wvalid_i && wready_o) state_q <= S_B;
            end
            default: begin
               if (!bvalid_o && !b_stall_i) begin
                  bvalid_o <= 1'b1;          // held until bready
               end else if (bvalid_o && bready_i) begin
                  bvalid_o <= 1'b0;
                  state_q  <= S_AW;
               end
            end
         endcase
      end
   end

   // a rejected beat leaves memory untouched
   always @(posedge clk_i) begin : mem_write
      int unsigned b;
      if ((state_q == S_W) && wvalid_i && wready_o && !err_q) begin
         for (b = 0; b < BE_DATA_W / 8; b++) begin
            if (wstrb_i[b]) mem[idx_q][b*8 +: 8] = wdata_i[b*8 +: 8];
         end
      end
   end

endmodule

// ==== test/tb_wt_write_path.sv ====
`timescale 1ns/1ps

module tb_wt_write_path;

   import wt_cache_pkg::*;

   localparam int unsigned ADDR_W      = DEF_ADDR_W;
   localparam int unsigned DATA_W      = DEF_DATA_W;
   localparam int unsigned BE_DATA_W   = DEF_BE_DATA_W;
   localparam int unsigned BUF_DEPTH   = DEF_BUF_DEPTH;
   localparam int unsigned WA_W        = ADDR_W - bytes_w(DATA_W);
   localparam int unsigned NB          = DATA_W / 8;
   localparam int unsigned BE_NB       = BE_DATA_W / 8;
   localparam int unsigned LANES       = BE_DATA_W / DATA_W;
   localparam int unsigned CHUNKS      = BE_DATA_W / 32;
   localparam int unsigned MEM_BEATS   = 64;
   localparam int unsigned NUM_STORES  = 200;
   localparam int unsigned CLK_HALF    = 20;
   localparam int unsigned WATCHDOG_NS = NUM_STORES * 40 * 2 * CLK_HALF;

   typedef struct packed {
      logic [WA_W-1:0]   addr;
      logic [DATA_W-1:0] data;
      logic [NB-1:0]     strb;
   } store_t;

   logic                 clk_i;
   logic                 reset;
   logic                 req_valid_i;
   logic                 req_ready_o;
   logic [WA_W-1:0]      req_addr_i;
   logic [DATA_W-1:0]    req_wdata_i;
   logic [NB-1:0]        req_wstrb_i;
   logic                 axi_awvalid_o;
   logic                 axi_awready_i;
   logic [ADDR_W-1:0]    axi_awaddr_o;
   logic [DEF_AXI_ID_W-1:0] axi_awid_o;
   logic [7:0]           axi_awlen_o;
   logic [2:0]           axi_awsize_o;
   logic [1:0]           axi_awburst_o;
   logic [3:0]           axi_awcache_o;
   logic                 axi_wvalid_o;
   logic                 axi_wready_i;
   logic [BE_DATA_W-1:0] axi_wdata_o;
   logic [BE_NB-1:0]     axi_wstrb_o;
   logic                 axi_wlast_o;
   logic                 axi_bvalid_i;
   logic                 axi_bready_o;
   logic [1:0]           axi_bresp_i;
   logic [15:0]          write_count_o;
   logic [15:0]          retry_count_o;
   logic                 drained_o;

   logic                 aw_stall;
   logic                 w_stall;
   logic                 b_stall;
   logic                 inject_err;
   integer               seed;
   int unsigned          assert_errs = 0;
   int unsigned          mem_errs = 0;

   store_t               ref_q[$];                 // accepted, not yet acknowledged
   logic [BE_DATA_W-1:0] ref_mem [MEM_BEATS];
   int unsigned          ref_count = 0;
   logic [ADDR_W-1:0]    exp_addr;
   logic [BE_DATA_W-1:0] exp_data;
   logic [BE_NB-1:0]     exp_strb;
   logic                 aw_seen;
   logic                 w_seen;
   logic                 replay;                   // last response was an error
   logic [ADDR_W-1:0]    last_awaddr;
   logic [BE_DATA_W-1:0] last_wdata;
   logic [BE_NB-1:0]     last_wstrb;
   logic [15:0]          ok_cnt;
   logic [15:0]          err_cnt;

   wt_write_path_top #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .BE_DATA_W (BE_DATA_W),
      .BUF_DEPTH (BUF_DEPTH),
      .AXI_ID_W  (DEF_AXI_ID_W)
   ) u_wt_write_path_top (.*);

   tb_axi_slave_model #(
      .ADDR_W    (ADDR_W),
      .BE_DATA_W (BE_DATA_W),
      .MEM_BEATS (MEM_BEATS)
   ) u_slave (
      .clk_i        (clk_i),
      .reset        (reset),
      .aw_stall_i   (aw_stall),
      .w_stall_i    (w_stall),
      .b_stall_i    (b_stall),
      .inject_err_i (inject_err),
      .awvalid_i    (axi_awvalid_o),
      .awready_o    (axi_awready_i),
      .awaddr_i     (axi_awaddr_o),
      .wvalid_i     (axi_wvalid_o),
      .wready_o     (axi_wready_i),
      .wdata_i      (axi_wdata_o),
      .wstrb_i      (axi_wstrb_o),
      .bvalid_o     (axi_bvalid_i),
      .bready_i     (axi_bready_o),
      .bresp_o      (axi_bresp_i)
   );

   always #CLK_HALF clk_i = ~clk_i;

   function automatic logic chance(input int unsigned pct);
      return ($unsigned($random(seed)) % 100) < pct;
   endfunction

   // same scrambled word pattern the slave starts from
   function automatic logic [BE_DATA_W-1:0] fill_beat(input int unsigned idx);
      logic [BE_DATA_W-1:0] v;
      int unsigned c;
      for (c = 0; c < CHUNKS; c++) begin
         v[c*32 +: 32] = (idx * CHUNKS + c) * 32'h9e37_79b9;
      end
      return v;
   endfunction

   // word address in bytes, rounded down to the beat
   function automatic logic [ADDR_W-1:0] beat_addr_of(input logic [WA_W-1:0] wa);
      logic [ADDR_W-1:0] byte_addr;
      byte_addr = ADDR_W'(wa) * ADDR_W'(NB);
      return byte_addr & ~ADDR_W'(BE_NB - 1);
   endfunction

   function automatic logic [BE_DATA_W-1:0] beat_data_of(input logic [DATA_W-1:0] w);
      logic [BE_DATA_W-1:0] v;
      int unsigned l;
      for (l = 0; l < LANES; l++) begin
         v[l*DATA_W +: DATA_W] = w;
      end
      return v;
   endfunction

   // word strobe placed in the lane its word offset selects
   function automatic logic [BE_NB-1:0] lane_strb_of(input logic [WA_W-1:0] wa,
                                                     input logic [NB-1:0]   s);
      logic [BE_NB-1:0] v;
      int unsigned b;
      for (b = 0; b < BE_NB; b++) begin
         v[b] = ((b / NB) == (32'(wa) % LANES)) ? s[b % NB] : 1'b0;
      end
      return v;
   endfunction

   task automatic apply_to_ref_mem(input store_t st);
      int unsigned beat;
      int unsigned lane;
      int unsigned b;
      beat = 32'(st.addr) / LANES;
      lane = 32'(st.addr) % LANES;
      for (b = 0; b < NB; b++) begin
         if (st.strb[b]) ref_mem[beat][lane*DATA_W + b*8 +: 8] = st.data[b*8 +: 8];
      end
   endtask

   task automatic report_fail(input string msg);
      assert_errs++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic draw_slave_controls(input int unsigned stall_pct, input int unsigned err_pct);
      aw_stall   <= chance(stall_pct);
      w_stall    <= chance(stall_pct);
      b_stall    <= chance(stall_pct);
      inject_err <= chance(err_pct);
   endtask

   task automatic issue_stores(input int unsigned n, input int unsigned stall_pct,
                               input int unsigned err_pct);
      int unsigned sent;
      sent = 0;
      while (sent < n) begin
         @(posedge clk_i);
         if (req_valid_i && req_ready_o) sent++;
         draw_slave_controls(stall_pct, err_pct);
         if (!req_valid_i || req_ready_o) begin    // a held store stays put
            if ((sent < n) && chance(75)) begin
               req_valid_i <= 1'b1;
               req_addr_i  <= WA_W'($unsigned($random(seed)) % (MEM_BEATS * LANES));
               req_wdata_i <= DATA_W'($random(seed));
               req_wstrb_i <= NB'($random(seed));
            end else begin
               req_valid_i <= 1'b0;
            end
         end
      end
   endtask

   // reference queue, memory image and handshake bookkeeping
   always @(posedge clk_i) begin : ref_model
      store_t st;
      store_t head;
      if (reset) begin
         aw_seen <= 1'b0;
         w_seen  <= 1'b0;
         replay  <= 1'b0;
         ok_cnt  <= '0;
         err_cnt <= '0;
      end else begin
         if (axi_awvalid_o && axi_awready_i) begin
            aw_seen     <= 1'b1;
            last_awaddr <= axi_awaddr_o;
         end
         if (axi_wvalid_o && axi_wready_i) begin
            w_seen     <= 1'b1;
            replay     <= 1'b0;
            last_wdata <= axi_wdata_o;
            last_wstrb <= axi_wstrb_o;
         end
         if (axi_bvalid_i && axi_bready_o) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            if (axi_bresp_i == AXI_RESP_OKAY) begin
               ok_cnt <= ok_cnt + 16'd1;
               if (ref_q.size() != 0) void'(ref_q.pop_front());
            end else begin
               err_cnt <= err_cnt + 16'd1;
               replay  <= 1'b1;
            end
         end
         if (req_valid_i && req_ready_o) begin
            st.addr = req_addr_i;
            st.data = req_wdata_i;
            st.strb = req_wstrb_i;
            ref_q.push_back(st);
            apply_to_ref_mem(st);
         end
         if (ref_q.size() != 0) begin
            head = ref_q[0];
            exp_addr <= beat_addr_of(head.addr);
            exp_strb <= lane_strb_of(head.addr, head.strb);
            exp_data <= beat_data_of(head.data);
         end
         ref_count <= ref_q.size();
      end
   end

   a_aw_map: assert property (@(posedge clk_i) disable iff (reset)
      axi_awvalid_o |-> (ref_count != 0) && (axi_awaddr_o == exp_addr))
      else report_fail("awaddr does not match the oldest accepted store");
   a_w_map: assert property (@(posedge clk_i) disable iff (reset)
      axi_wvalid_o |-> (axi_wdata_o == exp_data) && (axi_wstrb_o == exp_strb))
      else report_fail("wdata or wstrb does not match the oldest accepted store");
   a_aw_attr: assert property (@(posedge clk_i) disable iff (reset)
      axi_awvalid_o |-> (axi_awid_o == '0) && (axi_awsize_o == 3'($clog2(BE_NB)))
         && (axi_awburst_o == 2'b00) && (axi_awcache_o == 4'b0011))
      else report_fail("awid, awsize, awburst or awcache is wrong");
   a_w_order: assert property (@(posedge clk_i) disable iff (reset) axi_wvalid_o |-> aw_seen)
      else report_fail("wvalid raised before the address handshake");
   a_b_order: assert property (@(posedge clk_i) disable iff (reset) axi_bready_o |-> w_seen)
      else report_fail("bready raised before the data handshake");
   a_aw_hold: assert property (@(posedge clk_i) disable iff (reset)
      axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o))
      else report_fail("address phase dropped or changed before awready");
   a_w_hold: assert property (@(posedge clk_i) disable iff (reset)
      axi_wvalid_o && !axi_wready_i |=>
         axi_wvalid_o && $stable(axi_wdata_o) && $stable(axi_wstrb_o))
      else report_fail("data phase dropped or changed before wready");
   a_single_beat: assert property (@(posedge clk_i) disable iff (reset)
      (axi_awlen_o == 8'd0) && (axi_wlast_o == axi_wvalid_o))
      else report_fail("awlen is not zero or wlast differs from wvalid");
   a_reset_idle: assert property (@(posedge clk_i)
      reset || $fell(reset) |-> !axi_awvalid_o && !axi_wvalid_o && !axi_bready_o)
      else report_fail("a valid was high in or right after reset");
   a_reset_state: assert property (@(posedge clk_i) $fell(reset) |->
      req_ready_o && drained_o && (write_count_o == 16'd0) && (retry_count_o == 16'd0))
      else report_fail("ready, drained or counters wrong after reset");
   a_replay_aw: assert property (@(posedge clk_i) disable iff (reset)
      axi_awvalid_o && replay |-> axi_awaddr_o == last_awaddr)
      else report_fail("resent address differs from the failed one");
   a_replay_w: assert property (@(posedge clk_i) disable iff (reset)
      axi_wvalid_o && replay |-> (axi_wdata_o == last_wdata) && (axi_wstrb_o == last_wstrb))
      else report_fail("resent data differs from the failed one");
   a_counts: assert property (@(posedge clk_i) disable iff (reset)
      (write_count_o == ok_cnt) && (retry_count_o == err_cnt))
      else report_fail("write or retry count differs from the responses seen");
   a_full: assert property (@(posedge clk_i) disable iff (reset)
      !req_ready_o |-> ref_count == BUF_DEPTH)
      else report_fail("req_ready_o low with fewer than BUF_DEPTH stores outstanding");
   a_drained: assert property (@(posedge clk_i) disable iff (reset)
      (ref_count == 0) && ($past(ref_count) == 0) |-> drained_o)
      else report_fail("drained_o still low two cycles after the last completion");
   a_busy: assert property (@(posedge clk_i) disable iff (reset)
      (ref_count != 0) && ($past(ref_count) != 0) |-> !drained_o)
      else report_fail("drained_o high with stores outstanding");

   initial begin : stimulus
      int unsigned i;
      int unsigned stall_pct;
      seed        = 32'h7845_0e0a;
      clk_i       = 1'b0;
      reset       = 1'b1;
      req_valid_i = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_wstrb_i = '0;
      aw_stall    = 1'b0;
      w_stall     = 1'b0;
      b_stall     = 1'b0;
      inject_err  = 1'b0;
      for (i = 0; i < MEM_BEATS; i++) ref_mem[i] = fill_beat(i);
      repeat (10) @(posedge clk_i);
      reset <= 1'b0;
      stall_pct = 5 + ($unsigned($random(seed)) % 20);    // light traffic first
      issue_stores(NUM_STORES / 2, stall_pct, 10);
      stall_pct = 60 + ($unsigned($random(seed)) % 20);   // long stalls fill the buffer
      issue_stores(NUM_STORES / 2, stall_pct, 15);
      while (ref_count != 0) begin
         @(posedge clk_i);
         draw_slave_controls(20, 0);
      end
      repeat (4) @(posedge clk_i);
      for (i = 0; i < MEM_BEATS; i++) begin
         assert (u_slave.mem[i] == ref_mem[i]) else begin
            mem_errs++;
            $display("[FAIL] %0t: memory beat %0d holds %h, expected %h",
                     $time, i, u_slave.mem[i], ref_mem[i]);
         end
      end
      $display("errors: %0d assertion failures, %0d memory mismatches", assert_errs, mem_errs);
      if ((assert_errs == 0) && (mem_errs == 0)) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: stores were still outstanding when the time limit ran out");
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== wt_write_path_top.f ====
design/wt_cache_pkg.sv
design/wt_write_buffer.sv
design/wt_write_decode.sv
design/wt_write_channel_axi.sv
design/wt_write_result.sv
design/wt_write_path_top.sv
test/tb_axi_slave_model.sv
test/tb_wt_write_path.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the write path testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert --top-module tb_wt_write_path \
   -f wt_write_path_top.f -o sim_wt_write_path > build.log 2>&1 \
   && ./obj_dir/sim_wt_write_path > sim.log 2>&1 \
   || { echo "build or simulation run failed"; cat build.log; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

# the log decides the result
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
